//--- source/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// Store buffer entries
`define SB_DEPTH 4

// Word address width of the data memory, 64 words
`define MEM_ADDR_BITS 6

`endif

//--- source/mem_pkg.sv
`include "mem_macros.svh"

package mem_pkg;

  typedef enum logic [1:0] {
    mem_none  = 2'd0,
    mem_load  = 2'd1,
    mem_store = 2'd2,
    mem_fence = 2'd3
  } mem_op_e;

  typedef enum logic [1:0] {
    lsu_byte = 2'd0,
    lsu_half = 2'd1,
    lsu_word = 2'd2
  } lsu_size_e;

  typedef struct packed {
    lsu_size_e size;
    logic      is_unsigned;  // Zero-extend loads
  } lsu_op_t;

  typedef struct packed {
    logic [31:0] pc;
    mem_op_e     op;
    lsu_op_t     lsu;
    logic        wren;
    logic [4:0]  waddr;
    logic [31:0] address;
    logic [31:0] sdata;    // Store source
    logic [31:0] wdata;    // ALU result
  } mem_instr_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;    // Already lane-placed
    logic [3:0]  wstrb;    // Zero for loads and fences
    logic        load;
    logic        fence;
  } mem_req_t;

  typedef struct packed {
    logic        valid;
    logic        wren;
    logic [4:0]  waddr;
    logic [31:0] wdata;
    logic [31:0] pc;
  } wb_t;

  typedef struct packed {
    logic [`MEM_ADDR_BITS-1:0] addr;  // Word address
    logic [31:0]               wdata;
    logic [3:0]                wstrb;
  } sb_entry_t;

endpackage

//--- source/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit (
  input  mem_pkg::lsu_op_t lsu,
  input  logic [1:0]       offset,
  input  logic [31:0]      sdata,
  input  logic [31:0]      load_word,
  output logic [31:0]      store_data,
  output logic [3:0]       store_strb,
  output logic [31:0]      load_result
);
  import mem_pkg::*;

  logic [31:0] lane;

  // Byte or half copied into every lane, the strobe picks the real one
  always_comb begin
    case (lsu.size)
      lsu_byte: begin
        store_data = {4{sdata[7:0]}};
        store_strb = 4'b0001 << offset;
      end
      lsu_half: begin
        store_data = {2{sdata[15:0]}};
        store_strb = 4'b0011 << offset;
      end
      default: begin
        store_data = sdata;
        store_strb = 4'b1111;
      end
    endcase
  end

  assign lane = load_word >> {offset, 3'b000};  // Addressed byte down to bit 0

  always_comb begin
    case (lsu.size)
      lsu_byte: begin
        if (lsu.is_unsigned) begin
          load_result = {24'b0, lane[7:0]};
        end else begin
          load_result = {{24{lane[7]}}, lane[7:0]};
        end
      end
      lsu_half: begin
        if (lsu.is_unsigned) begin
          load_result = {16'b0, lane[15:0]};
        end else begin
          load_result = {{16{lane[15]}}, lane[15:0]};
        end
      end
      default: load_result = load_word;
    endcase
  end

endmodule

//--- source/store_buffer.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module store_buffer #(
  parameter int DEPTH = `SB_DEPTH
) (
  input  logic                      clk,
  input  logic                      rst,
  input  mem_pkg::mem_req_t         req,
  input  logic                      req_valid,
  output logic                      req_ready,
  output logic                      rsp_valid,
  output logic [31:0]               rsp_rdata,
  output logic                      wr_en,
  output mem_pkg::sb_entry_t        wr_entry,
  output logic                      rd_en,
  output logic [`MEM_ADDR_BITS-1:0] rd_addr,
  input  logic [31:0]               rd_data
);
  import mem_pkg::*;

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  sb_entry_t           entries [DEPTH];
  logic [PTR_BITS-1:0] head;
  logic [PTR_BITS-1:0] tail;
  logic [CNT_BITS-1:0] count;
  logic                empty;
  logic                full;
  logic                push;
  logic                pop;

  function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
    if (ptr == PTR_BITS'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty = (count == '0);
  assign full  = (count == CNT_BITS'(DEPTH));

  // Loads wait for the last drain write to land, so no forwarding is needed
  always_comb begin
    if (req.load) begin
      req_ready = empty & ~wr_en;
    end else if (req.fence) begin
      req_ready = empty;
    end else begin
      req_ready = ~full;
    end
  end

  assign push      = req_valid & req_ready & ~req.load & ~req.fence;
  assign pop       = ~empty;                 // Drain oldest entry every cycle
  assign rd_en     = req_valid & req_ready & req.load;
  assign rd_addr   = req.addr[`MEM_ADDR_BITS+1:2];
  assign rsp_rdata = rd_data;

  always_ff @(posedge clk) begin
    if (!rst) begin
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      wr_en     <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      if (push) begin
        tail <= next_ptr(tail);
      end
      if (pop) begin
        head <= next_ptr(head);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      wr_en     <= pop;
      rsp_valid <= rd_en;                    // Memory returns data one clock later
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      entries[tail].addr  <= req.addr[`MEM_ADDR_BITS+1:2];
      entries[tail].wdata <= req.wdata;
      entries[tail].wstrb <= req.wstrb;
    end
    if (pop) begin
      wr_entry <= entries[head];
    end
  end

endmodule

//--- source/data_memory.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module data_memory #(
  parameter int WORDS = 2 ** `MEM_ADDR_BITS
) (
  input  logic                      clk,
  input  logic                      wr_en,
  input  mem_pkg::sb_entry_t        wr_entry,
  input  logic                      rd_en,
  input  logic [`MEM_ADDR_BITS-1:0] rd_addr,
  output logic [31:0]               rd_data
);

  logic [31:0] words [WORDS];

  initial begin
    for (int i = 0; i < WORDS; i++) begin
      words[i] = 32'h0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < 4; b++) begin
        if (wr_entry.wstrb[b]) begin
          words[wr_entry.addr][8*b +: 8] <= wr_entry.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= words[rd_addr];  // Registered read
    end
  end

endmodule

//--- source/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
  input  logic                clk,
  input  logic                rst,
  input  mem_pkg::mem_instr_t in,
  input  logic                in_valid,
  output logic                in_ready,
  input  logic                flush,
  output mem_pkg::mem_req_t   req,
  output logic                req_valid,
  input  logic                req_ready,
  input  logic                rsp_valid,
  input  logic [31:0]         rsp_rdata,
  output logic [31:0]         load_word,
  output mem_pkg::lsu_op_t    lsu,
  output logic [1:0]          offset,
  input  logic [31:0]         load_result,
  input  logic [31:0]         store_data,
  input  logic [3:0]          store_strb,
  output mem_pkg::wb_t        wb
);
  import mem_pkg::*;

  typedef enum logic [1:0] {
    st_empty,
    st_request,
    st_response,
    st_retire
  } state_e;

  state_e     state_q;
  state_e     state_d;
  mem_instr_t instr_q;
  wb_t        wb_d;
  logic       active_q;   // Low for the first cycle out of reset
  logic       free;
  logic       in_fire;
  logic       writes_reg;

  always_comb begin
    case (state_q)
      st_empty, st_retire: free = active_q;
      st_response:         free = active_q & rsp_valid;
      default:             free = 1'b0;
    endcase
  end

  assign in_ready = free | flush;
  assign in_fire  = in_valid & in_ready;

  assign req_valid = (state_q == st_request);
  assign req = '{
    addr:  instr_q.address,
    wdata: store_data,
    wstrb: (instr_q.op == mem_store) ? store_strb : 4'h0,
    load:  (instr_q.op == mem_load),
    fence: (instr_q.op == mem_fence)
  };

  // One operand word to the load unit, store source or returned memory word
  assign load_word = (instr_q.op == mem_store) ? instr_q.sdata : rsp_rdata;
  assign lsu       = instr_q.lsu;
  assign offset    = instr_q.address[1:0];

  assign writes_reg = (instr_q.op == mem_none) | (instr_q.op == mem_load);

  always_comb begin
    state_d = state_q;
    wb_d    = '0;
    case (state_q)
      st_request: begin
        if (req_ready) begin
          state_d = (instr_q.op == mem_load) ? st_response : st_retire;
        end
      end
      st_response: begin
        if (rsp_valid) begin
          wb_d.valid = 1'b1;
          wb_d.wdata = load_result;
          state_d    = st_empty;
        end
      end
      st_retire: begin
        wb_d.valid = 1'b1;
        wb_d.wdata = instr_q.wdata;
        state_d    = st_empty;
      end
      default: state_d = st_empty;
    endcase
    wb_d.wren  = wb_d.valid & writes_reg & instr_q.wren & (|instr_q.waddr);  // x0 never written
    wb_d.waddr = instr_q.waddr;
    wb_d.pc    = instr_q.pc;
    if (flush) begin
      state_d    = st_empty;
      wb_d.valid = 1'b0;
      wb_d.wren  = 1'b0;
    end
    if (in_fire) begin
      state_d = (in.op == mem_none) ? st_retire : st_request;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state_q  <= st_empty;
      active_q <= 1'b0;
      wb       <= '0;
    end else begin
      state_q  <= state_d;
      active_q <= 1'b1;
      wb       <= wb_d;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      instr_q <= in;
    end
  end

endmodule

//--- source/mem_subsystem.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_subsystem (
  input  logic                clk,
  input  logic                rst,
  input  mem_pkg::mem_instr_t in,
  input  logic                in_valid,
  output logic                in_ready,
  input  logic                flush,
  output mem_pkg::wb_t        wb
);
  import mem_pkg::*;

  mem_req_t                  req;
  logic                      req_valid;
  logic                      req_ready;
  logic                      rsp_valid;
  logic [31:0]               rsp_rdata;
  logic [31:0]               load_word;
  lsu_op_t                   lsu;
  logic [1:0]                offset;
  logic [31:0]               load_result;
  logic [31:0]               store_data;
  logic [3:0]                store_strb;
  logic                      wr_en;
  sb_entry_t                 wr_entry;
  logic                      rd_en;
  logic [`MEM_ADDR_BITS-1:0] rd_addr;
  logic [31:0]               rd_data;

  memory_stage stage0 (
    .clk         (clk),
    .rst         (rst),
    .in          (in),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .flush       (flush),
    .req         (req),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .rsp_valid   (rsp_valid),
    .rsp_rdata   (rsp_rdata),
    .load_word   (load_word),
    .lsu         (lsu),
    .offset      (offset),
    .load_result (load_result),
    .store_data  (store_data),
    .store_strb  (store_strb),
    .wb          (wb)
  );

  load_store_unit lsu0 (
    .lsu         (lsu),
    .offset      (offset),
    .sdata       (load_word),    // Carries the store source for stores
    .load_word   (load_word),
    .store_data  (store_data),
    .store_strb  (store_strb),
    .load_result (load_result)
  );

  store_buffer #(
    .DEPTH (`SB_DEPTH)
  ) sb0 (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_rdata (rsp_rdata),
    .wr_en     (wr_en),
    .wr_entry  (wr_entry),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  data_memory mem0 (
    .clk      (clk),
    .wr_en    (wr_en),
    .wr_entry (wr_entry),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

endmodule

//--- verification/mem_subsystem_checker.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_subsystem_checker #(
  parameter int CNT_W = $clog2(`SB_DEPTH + 1)
) (
  input logic              clk,
  input logic              rst,
  input logic              flush,
  input logic              in_ready,
  input mem_pkg::wb_t      wb,
  input mem_pkg::mem_req_t req,
  input logic              req_valid,
  input logic              req_ready,
  input logic              rsp_valid,
  input logic              wr_en,
  input logic [CNT_W-1:0]  sb_count
);

  localparam logic [CNT_W-1:0] MAX_COUNT = CNT_W'(`SB_DEPTH);

  int fail_count = 0;

  reset_quiet: assert property (@(posedge clk)
    $rose(rst) |-> !in_ready && !wb.valid && !req_valid && !wr_en && !rsp_valid)
  else begin
    $error("Outputs active on the first cycle out of reset");
    fail_count++;
  end

  // A flush may drop the request, otherwise it waits unchanged
  req_hold: assert property (@(posedge clk) disable iff (!rst)
    req_valid && !req_ready && !flush |=> req_valid && $stable(req))
  else begin
    $error("Request changed or dropped while stalled");
    fail_count++;
  end

  no_x0_write: assert property (@(posedge clk) disable iff (!rst)
    wb.wren |-> wb.waddr != 5'd0)
  else begin
    $error("Write-back enabled for register zero");
    fail_count++;
  end

  sb_bounded: assert property (@(posedge clk) disable iff (!rst)
    sb_count <= MAX_COUNT)
  else begin
    $error("Store buffer count above its depth");
    fail_count++;
  end

  rsp_after_load: assert property (@(posedge clk) disable iff (!rst)
    rsp_valid |-> $past(req_valid && req_ready && req.load))
  else begin
    $error("Response without a load transfer one cycle earlier");
    fail_count++;
  end

endmodule

bind mem_subsystem mem_subsystem_checker chk0 (
  .clk       (clk),
  .rst       (rst),
  .flush     (flush),
  .in_ready  (in_ready),
  .wb        (wb),
  .req       (req),
  .req_valid (req_valid),
  .req_ready (req_ready),
  .rsp_valid (rsp_valid),
  .wr_en     (wr_en),
  .sb_count  (sb0.count)
);

//--- verification/mem_subsystem_tb.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_subsystem_tb;
  import mem_pkg::*;

  localparam int MAX_CYCLES = 5000;  // About 300 instructions at up to 8 cycles each

  logic        clk;
  logic        rst;
  mem_instr_t  in;
  logic        in_valid;
  logic        in_ready;
  logic        flush;
  wb_t         wb;

  logic [7:0]  ref_mem [256];  // Byte image of the data memory
  wb_t         exp_q [$];
  wb_t         exp_wb;
  logic [31:0] pc_next;
  integer      seed;
  int          cycles;
  int          errors;
  int          checks;
  int          test_err_start;
  int          tests_passed;
  int          tests_failed;
  string       cur_test;

  mem_subsystem dut0 (
    .clk      (clk),
    .rst      (rst),
    .in       (in),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .flush    (flush),
    .wb       (wb)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  function automatic string wb_text(input wb_t w);
    return $sformatf("wren %b waddr %0d wdata %h pc %h", w.wren, w.waddr, w.wdata, w.pc);
  endfunction

  // Each retirement against the oldest outstanding instruction
  always @(negedge clk) begin
    if (rst && wb.valid) begin
      checks++;
      assert (exp_q.size() != 0) else begin
        $display("Retirement at pc %h with no instruction outstanding", wb.pc);
        errors++;
      end
      if (exp_q.size() != 0) begin
        exp_wb = exp_q.pop_front();
        assert (wb == exp_wb) else begin
          $display("[FAIL] %s expected %s actual %s", cur_test,
                   wb_text(exp_wb), wb_text(wb));
          errors++;
        end
      end
    end
  end

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic int nbytes(input lsu_size_e size);
    case (size)
      lsu_byte: return 1;
      lsu_half: return 2;
      default:  return 4;
    endcase
  endfunction

  function automatic void store_ref(input logic [7:0] a, input lsu_size_e size,
                                    input logic [31:0] d);
    for (int k = 0; k < nbytes(size); k++) begin
      ref_mem[a] = d[7:0];  // Little-endian
      d = d >> 8;
      a = a + 8'd1;
    end
  endfunction

  function automatic logic [31:0] load_ref(input logic [7:0] a, input lsu_size_e size,
                                           input logic uns);
    logic [31:0] w;
    w = '0;
    for (int k = nbytes(size) - 1; k >= 0; k--) begin
      w = {w[23:0], ref_mem[a + 8'(k)]};
    end
    case (size)
      lsu_byte: return uns ? {24'h0, w[7:0]} : {{24{w[7]}}, w[7:0]};
      lsu_half: return uns ? {16'h0, w[15:0]} : {{16{w[15]}}, w[15:0]};
      default:  return w;
    endcase
  endfunction

  task automatic send(input mem_instr_t instr);
    logic accepted;
    in = instr;
    in_valid = 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = in_ready;
      @(posedge clk);
      #1;
    end
    in_valid = 1'b0;
  endtask

  task automatic issue(input mem_op_e op, input lsu_size_e size, input logic uns,
                       input logic [4:0] waddr, input logic [31:0] addr,
                       input logic [31:0] sdata, input logic kill);
    mem_instr_t  instr;
    wb_t         e;
    logic [31:0] r;
    r = rand32();
    instr = '0;
    instr.pc = pc_next;
    instr.op = op;
    instr.lsu.size = size;
    instr.lsu.is_unsigned = uns;
    instr.wren = (op == mem_none) ? 1'b1 : r[31];
    instr.waddr = waddr;
    instr.address = addr;
    instr.sdata = sdata;
    instr.wdata = rand32();
    pc_next = pc_next + 32'd4;
    e = '0;
    e.valid = 1'b1;
    e.waddr = waddr;
    e.pc = instr.pc;
    e.wren = (op == mem_none || op == mem_load) && instr.wren && waddr != 5'd0;
    e.wdata = (op == mem_load) ? load_ref(addr[7:0], size, uns) : instr.wdata;
    if (op == mem_store) begin
      store_ref(addr[7:0], size, sdata);
    end
    if (!kill) begin
      exp_q.push_back(e);
    end
    send(instr);
    if (kill) begin
      flush = 1'b1;  // Hits the instruction just taken
      @(posedge clk);
      #1;
      flush = 1'b0;
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_err_start = errors + dut0.chk0.fail_count;
  endtask

  task automatic end_test();
    int failed;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (4) @(posedge clk);
    #1;
    failed = errors + dut0.chk0.fail_count - test_err_start;
    $display("%-16s finished with %0d errors", cur_test, failed);
    if (failed == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
  endtask

  task automatic non_memory_ops();
    logic [31:0] r;
    start_test("non_memory");
    for (int k = 0; k < 40; k++) begin
      r = rand32();
      issue(mem_none, lsu_word, 1'b0, (k % 5 == 0) ? 5'd0 : r[4:0], 32'h0, r, 1'b0);
    end
    end_test();
  endtask

  task automatic word_access();
    logic [31:0] addrs [$];
    logic [31:0] r;
    start_test("word_store_load");
    for (int k = 0; k < 30; k++) begin
      r = rand32();
      addrs.push_back({24'h0, r[7:2], 2'b00});
      issue(mem_store, lsu_word, 1'b0, r[12:8], addrs[k], rand32(), 1'b0);
    end
    for (int k = 0; k < 30; k++) begin
      r = rand32();
      issue(mem_load, lsu_word, 1'b0, r[4:0], addrs[k], 32'h0, 1'b0);
    end
    end_test();
  endtask

  task automatic sub_word_access();
    logic [31:0] base;
    logic [31:0] r;
    start_test("byte_half");
    for (int rep = 0; rep < 8; rep++) begin
      r = rand32();
      base = {24'h0, r[7:2], 2'b00};
      for (int off = 0; off < 4; off++) begin
        issue(mem_store, lsu_byte, 1'b0, r[4:0], base + 32'(off), rand32(), 1'b0);
      end
      for (int off = 0; off < 4; off++) begin
        issue(mem_load, lsu_byte, 1'b0, r[4:0], base + 32'(off), 32'h0, 1'b0);
        issue(mem_load, lsu_byte, 1'b1, r[12:8], base + 32'(off), 32'h0, 1'b0);
      end
      for (int off = 0; off < 4; off += 2) begin
        issue(mem_store, lsu_half, 1'b0, r[4:0], base + 32'(off), rand32(), 1'b0);
        issue(mem_load, lsu_half, 1'b0, r[4:0], base + 32'(off), 32'h0, 1'b0);
        issue(mem_load, lsu_half, 1'b1, r[12:8], base + 32'(off), 32'h0, 1'b0);
      end
    end
    end_test();
  endtask

  task automatic store_burst();
    logic [31:0] base;
    logic [31:0] r;
    start_test("back_pressure");
    for (int rep = 0; rep < 3; rep++) begin
      r = rand32();
      base = {24'h0, r[7:2], 2'b00};
      for (int k = 0; k < 2 * `SB_DEPTH + 2; k++) begin
        issue(mem_store, lsu_word, 1'b0, r[4:0], base, rand32(), 1'b0);
      end
      issue(mem_load, lsu_word, 1'b0, r[12:8], base, 32'h0, 1'b0);
    end
    end_test();
  endtask

  task automatic flush_kill();
    logic [31:0] base;
    logic [31:0] r;
    start_test("flush");
    for (int rep = 0; rep < 4; rep++) begin
      r = rand32();
      base = {24'h0, r[7:2], 2'b00};
      issue(mem_store, lsu_word, 1'b0, r[4:0], base, rand32(), 1'b0);
      issue(mem_load, lsu_word, 1'b0, r[12:8], base, 32'h0, 1'b1);  // Held behind the drain
      issue(mem_none, lsu_word, 1'b0, r[20:16], 32'h0, 32'h0, 1'b1);
      issue(mem_load, lsu_word, 1'b0, r[12:8], base, 32'h0, 1'b1);  // Response comes too late
      issue(mem_load, lsu_word, 1'b0, r[12:8], base, 32'h0, 1'b0);
      issue(mem_none, lsu_word, 1'b0, r[20:16], 32'h0, 32'h0, 1'b0);
    end
    end_test();
  endtask

  task automatic fence_order();
    logic [31:0] base;
    logic [31:0] r;
    start_test("fence");
    for (int rep = 0; rep < 5; rep++) begin
      r = rand32();
      base = {24'h0, r[7:2], 2'b00};
      issue(mem_store, lsu_word, 1'b0, r[4:0], base, rand32(), 1'b0);
      issue(mem_store, lsu_byte, 1'b0, r[4:0], base + 32'd1, rand32(), 1'b0);
      issue(mem_fence, lsu_word, 1'b0, r[12:8], 32'h0, 32'h0, 1'b0);
      issue(mem_load, lsu_word, 1'b0, r[12:8], base, 32'h0, 1'b0);
      issue(mem_load, lsu_byte, 1'b1, r[20:16], base + 32'd1, 32'h0, 1'b0);
    end
    end_test();
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b0;
    in = '0;
    in_valid = 1'b0;
    flush = 1'b0;
    seed = 37928;
    cycles = 0;
    errors = 0;
    checks = 0;
    tests_passed = 0;
    tests_failed = 0;
    pc_next = 32'h0000_1000;
    ref_mem = '{default: 8'h00};
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    non_memory_ops();
    word_access();
    sub_word_access();
    store_burst();
    flush_kill();
    fence_order();
    $display("Summary: %0d passed, %0d failed, %0d retirements checked",
             tests_passed, tests_failed, checks);
    if (tests_failed == 0 && errors == 0 && dut0.chk0.fail_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- mem_subsystem.f
+incdir+source
source/mem_pkg.sv
source/load_store_unit.sv
source/store_buffer.sv
source/data_memory.sv
source/memory_stage.sv
source/mem_subsystem.sv
verification/mem_subsystem_checker.sv
verification/mem_subsystem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module mem_subsystem_tb \
  -f mem_subsystem.f \
  -o mem_subsystem_sim

output=$(./obj_dir/mem_subsystem_sim +verilator+error+limit+100 || true)
echo "$output"

if echo "$output" | grep -q "^Test passed$"; then
  exit 0
fi
exit 1
